/* src/exec_pkg.sv */
`default_nettype none

package exec_pkg;

   // ##############################
   // widths and constants
   // ##############################
   localparam int REG_W      = 32;                 // data word
   localparam int REG_ADDR_W = 5;                  // register index
   localparam int NUM_REGS   = 32;                 // r0 to r31
   localparam int INST_W     = 32;                 // instruction word
   localparam int IMM_W      = 16;                 // i-type immediate field
   localparam int SHAMT_W    = 5;                  // shift amount field

   localparam logic [REG_W-1:0] ZERO_WORD = '0;    // all-zero data word

   // ##############################
   // instruction encodings
   // ##############################
   // primary opcode, inst[31:26]
   typedef enum logic [5:0] {
      SPECIAL = 6'h00,                             // r-type, decoded by funct
      ADDIU   = 6'h09,
      SLTI    = 6'h0a,
      SLTIU   = 6'h0b,
      ANDI    = 6'h0c,
      ORI     = 6'h0d,
      XORI    = 6'h0e,
      LUI     = 6'h0f
   } opcode_e;

   // function field of SPECIAL, inst[5:0]
   typedef enum logic [5:0] {
      F_SLL  = 6'h00,                              // shift by shamt
      F_SRL  = 6'h02,
      F_SRA  = 6'h03,
      F_SLLV = 6'h04,                              // shift by rs
      F_SRLV = 6'h06,
      F_SRAV = 6'h07,
      F_ADD  = 6'h20,                              // wraps, no trap here
      F_ADDU = 6'h21,
      F_SUB  = 6'h22,                              // wraps, no trap here
      F_SUBU = 6'h23,
      F_AND  = 6'h24,
      F_OR   = 6'h25,
      F_XOR  = 6'h26,
      F_NOR  = 6'h27,
      F_SLT  = 6'h2a,
      F_SLTU = 6'h2b
   } funct_e;

   // ##############################
   // execute control
   // ##############################
   typedef enum logic [3:0] {
      NOP  = 4'd0,                                 // bubble
      AND  = 4'd1,
      OR   = 4'd2,
      XOR  = 4'd3,
      NOR  = 4'd4,
      SLL  = 4'd5,
      SRL  = 4'd6,
      SRA  = 4'd7,
      ADD  = 4'd8,
      SUB  = 4'd9,
      SLT  = 4'd10,
      SLTU = 4'd11
   } alu_op_e;

   // result group picked at the end of execute
   typedef enum logic [1:0] {
      RES_NOP   = 2'd0,
      RES_LOGIC = 2'd1,
      RES_SHIFT = 2'd2,
      RES_ARITH = 2'd3
   } alu_sel_e;

   // ##############################
   // stage payloads
   // ##############################
   typedef struct packed {
      alu_op_e                aluop;               // operation
      alu_sel_e               alusel;              // result group
      logic [REG_W-1:0]       reg1;                // operand a, value to shift
      logic [REG_W-1:0]       reg2;                // operand b, shift amount low bits
      logic [REG_ADDR_W-1:0]  wd;                  // destination register
      logic                   wreg;                // write enable
   } ex_req_t;

   typedef struct packed {
      logic [REG_ADDR_W-1:0]  wd;                  // destination register
      logic                   wreg;                // write enable
      logic [REG_W-1:0]       wdata;               // result word
   } ex_res_t;

endpackage

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  wire                              clk,
   input  wire                              rst_i,
   input  wire                              we_i,       // write strobe
   input  wire  [exec_pkg::REG_ADDR_W-1:0]  waddr_i,
   input  wire  [exec_pkg::REG_W-1:0]       wdata_i,
   input  wire  [exec_pkg::REG_ADDR_W-1:0]  raddr1_i,   // port 1 address
   input  wire  [exec_pkg::REG_ADDR_W-1:0]  raddr2_i,   // port 2 address
   output logic [exec_pkg::REG_W-1:0]       rdata1_o,
   output logic [exec_pkg::REG_W-1:0]       rdata2_o
);
   import exec_pkg::*;

   logic [REG_W-1:0] regs [1:NUM_REGS-1];               // r0 has no storage

   // ##############################
   // write port
   // ##############################
   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         for (int i = 1; i < NUM_REGS; i++)
         begin
            regs[i] <= ZERO_WORD;                       // known start state
         end
      end
      else if (we_i && (waddr_i != '0))                 // r0 writes dropped
      begin
         regs[waddr_i] <= wdata_i;
      end
   end

   // ##############################
   // read ports
   // ##############################
   // no write-through here
   // a same-cycle write reaches decode via the wb forward
   always_comb
   begin
      if (raddr1_i == '0)
         rdata1_o = ZERO_WORD;                          // r0 hardwired
      else
         rdata1_o = regs[raddr1_i];
   end

   always_comb
   begin
      if (raddr2_i == '0)
         rdata2_o = ZERO_WORD;                          // r0 hardwired
      else
         rdata2_o = regs[raddr2_i];
   end

endmodule

`default_nettype wire

/* src/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
   input  wire                              clk,
   input  wire                              rst_i,
   input  wire                              inst_valid_i,   // level strobe
   input  wire  [exec_pkg::INST_W-1:0]      inst_i,
   output logic [exec_pkg::REG_ADDR_W-1:0]  raddr1_o,       // to reg file
   output logic [exec_pkg::REG_ADDR_W-1:0]  raddr2_o,
   input  wire  [exec_pkg::REG_W-1:0]       rdata1_i,       // from reg file
   input  wire  [exec_pkg::REG_W-1:0]       rdata2_i,
   input  wire  exec_pkg::ex_res_t          ex_fwd_i,       // result now in execute
   input  wire  exec_pkg::ex_res_t          wb_fwd_i,       // result now in write-back
   output exec_pkg::ex_req_t                ex_req_o        // id/ex register
);
   import exec_pkg::*;

   // instruction fields
   opcode_e                opcode;
   funct_e                 funct;
   logic [REG_ADDR_W-1:0]  rs;
   logic [REG_ADDR_W-1:0]  rt;
   logic [REG_ADDR_W-1:0]  rd;
   logic [SHAMT_W-1:0]     shamt;
   logic [IMM_W-1:0]       imm;

   // decode results
   logic                   is_special;
   logic                   fixed_shift;                      // sll, srl, sra
   logic                   var_shift;                        // sllv, srlv, srav
   alu_op_e                r_op;                             // op from funct
   alu_op_e                dec_op;
   alu_sel_e               dec_sel;
   logic [REG_ADDR_W-1:0]  dst;
   logic                   use_src1;
   logic                   use_src2;
   logic [REG_W-1:0]       imm_val;                          // second operand if no rt read
   logic [REG_W-1:0]       op1;
   logic [REG_W-1:0]       op2;
   logic                   bubble;

   // id/ex register
   alu_op_e                aluop_q;
   alu_sel_e               alusel_q;
   logic                   wreg_q;
   logic [REG_W-1:0]       reg1_q;
   logic [REG_W-1:0]       reg2_q;
   logic [REG_ADDR_W-1:0]  wd_q;

   // priority r0, then execute, then write-back, then reg file
   function automatic logic [REG_W-1:0] fwd_operand(
      input logic [REG_ADDR_W-1:0] addr,
      input logic [REG_W-1:0]      rf_val,
      input ex_res_t               ex_r,
      input ex_res_t               wb_r
   );
      if (addr == '0)
         return ZERO_WORD;
      else if (ex_r.wreg && (ex_r.wd == addr))
         return ex_r.wdata;                                  // youngest result wins
      else if (wb_r.wreg && (wb_r.wd == addr))
         return wb_r.wdata;
      else
         return rf_val;
   endfunction

   // ##############################
   // field split
   // ##############################
   assign opcode = opcode_e'(inst_i[31:26]);
   assign rs     = inst_i[25:21];
   assign rt     = inst_i[20:16];
   assign rd     = inst_i[15:11];
   assign shamt  = inst_i[10:6];
   assign funct  = funct_e'(inst_i[5:0]);
   assign imm    = inst_i[IMM_W-1:0];

   assign is_special  = (opcode == SPECIAL);
   assign fixed_shift = (funct == F_SLL) || (funct == F_SRL) || (funct == F_SRA);
   assign var_shift   = (funct == F_SLLV) || (funct == F_SRLV) || (funct == F_SRAV);

   // ##############################
   // operation select
   // ##############################
   always_comb
   begin
      case (funct)
         F_AND:          r_op = AND;
         F_OR:           r_op = OR;
         F_XOR:          r_op = XOR;
         F_NOR:          r_op = NOR;
         F_SLL, F_SLLV:  r_op = SLL;
         F_SRL, F_SRLV:  r_op = SRL;
         F_SRA, F_SRAV:  r_op = SRA;
         F_ADD, F_ADDU:  r_op = ADD;                         // both wrap
         F_SUB, F_SUBU:  r_op = SUB;
         F_SLT:          r_op = SLT;
         F_SLTU:         r_op = SLTU;
         default:        r_op = NOP;                         // unknown funct
      endcase
   end

   always_comb
   begin
      case (opcode)
         SPECIAL:        dec_op = r_op;
         ANDI:           dec_op = AND;
         ORI, LUI:       dec_op = OR;                        // lui is 0 | imm<<16
         XORI:           dec_op = XOR;
         ADDIU:          dec_op = ADD;
         SLTI:           dec_op = SLT;
         SLTIU:          dec_op = SLTU;
         default:        dec_op = NOP;                       // unsupported opcode
      endcase
   end

   always_comb
   begin
      case (dec_op)
         AND, OR, XOR, NOR:   dec_sel = RES_LOGIC;
         SLL, SRL, SRA:       dec_sel = RES_SHIFT;
         ADD, SUB, SLT, SLTU: dec_sel = RES_ARITH;
         default:             dec_sel = RES_NOP;
      endcase
   end

   // ##############################
   // operand sources
   // ##############################
   assign dst      = is_special ? rd : rt;
   assign raddr1_o = (is_special && (fixed_shift || var_shift)) ? rt : rs;
   assign raddr2_o = (is_special && var_shift) ? rs : rt;
   assign use_src1 = (opcode != LUI);
   assign use_src2 = is_special && !fixed_shift;

   always_comb
   begin
      case (opcode)
         SPECIAL:          imm_val = {{(REG_W-SHAMT_W){1'b0}}, shamt};
         ANDI, ORI, XORI:  imm_val = {{(REG_W-IMM_W){1'b0}}, imm};          // zero ext
         LUI:              imm_val = {imm, {(REG_W-IMM_W){1'b0}}};
         default:          imm_val = {{(REG_W-IMM_W){imm[IMM_W-1]}}, imm};  // sign ext
      endcase
   end

   assign op1 = use_src1 ? fwd_operand(raddr1_o, rdata1_i, ex_fwd_i, wb_fwd_i) : ZERO_WORD;
   assign op2 = use_src2 ? fwd_operand(raddr2_o, rdata2_i, ex_fwd_i, wb_fwd_i) : imm_val;

   assign bubble = !inst_valid_i || (dec_op == NOP) || (dst == '0);

   // ##############################
   // id/ex register
   // ##############################
   always_ff @(posedge clk)
   begin
      if (rst_i || bubble)
      begin
         wreg_q   <= 1'b0;
         aluop_q  <= NOP;
         alusel_q <= RES_NOP;
      end
      else
      begin
         wreg_q   <= 1'b1;
         aluop_q  <= dec_op;
         alusel_q <= dec_sel;
      end
   end

   always_ff @(posedge clk)
   begin
      reg1_q <= op1;
      reg2_q <= op2;
      wd_q   <= dst;
   end

   assign ex_req_o = '{aluop: aluop_q, alusel: alusel_q, reg1: reg1_q,
                       reg2: reg2_q, wd: wd_q, wreg: wreg_q};

endmodule

`default_nettype wire

/* src/ex.sv */
`timescale 1ns/1ps
`default_nettype none

module ex (
   input  wire exec_pkg::ex_req_t  ex_req_i,    // from id/ex
   output exec_pkg::ex_res_t       ex_res_o     // to ex/wb and forwarding
);
   import exec_pkg::*;

   logic [REG_W-1:0]    logic_res;
   logic [REG_W-1:0]    shift_res;
   logic [REG_W-1:0]    arith_res;
   logic [REG_W-1:0]    reg2_mux;               // reg2 or its negation
   logic [REG_W-1:0]    sum;
   logic [SHAMT_W-1:0]  shamt;
   logic                lt_signed;
   logic                lt_unsigned;
   logic                lt;
   logic [REG_W-1:0]    wdata;

   // ##############################
   // logic
   // ##############################
   always_comb
   begin
      case (ex_req_i.aluop)
         AND:     logic_res = ex_req_i.reg1 & ex_req_i.reg2;
         OR:      logic_res = ex_req_i.reg1 | ex_req_i.reg2;
         XOR:     logic_res = ex_req_i.reg1 ^ ex_req_i.reg2;
         NOR:     logic_res = ~(ex_req_i.reg1 | ex_req_i.reg2);
         default: logic_res = ZERO_WORD;
      endcase
   end

   // ##############################
   // shift
   // ##############################
   assign shamt = ex_req_i.reg2[SHAMT_W-1:0];    // upper bits ignored

   always_comb
   begin
      case (ex_req_i.aluop)
         SLL:     shift_res = ex_req_i.reg1 << shamt;
         SRL:     shift_res = ex_req_i.reg1 >> shamt;
         SRA:     shift_res = $signed(ex_req_i.reg1) >>> shamt;   // sign fill
         default: shift_res = ZERO_WORD;
      endcase
   end

   // ##############################
   // arithmetic
   // ##############################
   // sub and slt both go through the adder
   assign reg2_mux = ((ex_req_i.aluop == SUB) || (ex_req_i.aluop == SLT))
                   ? (~ex_req_i.reg2) + 1'b1
                   : ex_req_i.reg2;
   assign sum = ex_req_i.reg1 + reg2_mux;       // wraps mod 2^32

   // neg vs pos, or same sign and negative difference
   assign lt_signed = (ex_req_i.reg1[REG_W-1] && !ex_req_i.reg2[REG_W-1])
                   || (!ex_req_i.reg1[REG_W-1] && !ex_req_i.reg2[REG_W-1] && sum[REG_W-1])
                   || (ex_req_i.reg1[REG_W-1] && ex_req_i.reg2[REG_W-1] && sum[REG_W-1]);
   assign lt_unsigned = (ex_req_i.reg1 < ex_req_i.reg2);
   assign lt          = (ex_req_i.aluop == SLT) ? lt_signed : lt_unsigned;

   always_comb
   begin
      case (ex_req_i.aluop)
         ADD, SUB:   arith_res = sum;
         SLT, SLTU:  arith_res = {{(REG_W-1){1'b0}}, lt};      // 0 or 1
         default:    arith_res = ZERO_WORD;
      endcase
   end

   // ##############################
   // result select
   // ##############################
   always_comb
   begin
      case (ex_req_i.alusel)
         RES_LOGIC:  wdata = logic_res;
         RES_SHIFT:  wdata = shift_res;
         RES_ARITH:  wdata = arith_res;
         default:    wdata = ZERO_WORD;          // bubble
      endcase
   end

   assign ex_res_o = '{wd: ex_req_i.wd, wreg: ex_req_i.wreg, wdata: wdata};

endmodule

`default_nettype wire

/* src/write_back.sv */
`timescale 1ns/1ps
`default_nettype none

module write_back (
   input  wire                              clk,
   input  wire                              rst_i,
   input  wire  exec_pkg::ex_res_t          ex_res_i,   // from execute
   output exec_pkg::ex_res_t                wb_o,       // reg file write and forwarding
   output logic                             wb_we_o,    // observed write port
   output logic [exec_pkg::REG_ADDR_W-1:0]  wb_addr_o,
   output logic [exec_pkg::REG_W-1:0]       wb_data_o
);
   import exec_pkg::*;

   logic                   wreg_q;
   logic [REG_ADDR_W-1:0]  wd_q;
   logic [REG_W-1:0]       wdata_q;

   // ##############################
   // ex/wb register
   // ##############################
   always_ff @(posedge clk)
   begin
      if (rst_i)
         wreg_q <= 1'b0;                         // no write after reset
      else
         wreg_q <= ex_res_i.wreg;
   end

   always_ff @(posedge clk)
   begin
      wd_q    <= ex_res_i.wd;
      wdata_q <= ex_res_i.wdata;
   end

   // ##############################
   // outputs
   // ##############################
   assign wb_o = '{wd: wd_q, wreg: wreg_q, wdata: wdata_q};

   assign wb_we_o   = wreg_q;
   assign wb_addr_o = wd_q;
   assign wb_data_o = wdata_q;

endmodule

`default_nettype wire

/* src/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core (
   input  wire                              clk,
   input  wire                              rst_i,
   input  wire                              inst_valid_i,   // one instruction per cycle
   input  wire  [exec_pkg::INST_W-1:0]      inst_i,
   output logic                             wb_we_o,        // write-back port, 2 edges later
   output logic [exec_pkg::REG_ADDR_W-1:0]  wb_addr_o,
   output logic [exec_pkg::REG_W-1:0]       wb_data_o
);
   import exec_pkg::*;

   logic [REG_ADDR_W-1:0]  raddr1;
   logic [REG_ADDR_W-1:0]  raddr2;
   logic [REG_W-1:0]       rdata1;
   logic [REG_W-1:0]       rdata2;
   ex_req_t                ex_req;              // id/ex to execute
   ex_res_t                ex_res;              // execute to ex/wb, ex forward
   ex_res_t                wb_res;              // ex/wb to reg file, wb forward

   reg_file u_reg_file (
      .clk        (clk),
      .rst_i      (rst_i),
      .we_i       (wb_res.wreg),
      .waddr_i    (wb_res.wd),
      .wdata_i    (wb_res.wdata),
      .raddr1_i   (raddr1),
      .raddr2_i   (raddr2),
      .rdata1_o   (rdata1),
      .rdata2_o   (rdata2)
   );

   inst_decode u_inst_decode (
      .clk          (clk),
      .rst_i        (rst_i),
      .inst_valid_i (inst_valid_i),
      .inst_i       (inst_i),
      .raddr1_o     (raddr1),
      .raddr2_o     (raddr2),
      .rdata1_i     (rdata1),
      .rdata2_i     (rdata2),
      .ex_fwd_i     (ex_res),
      .wb_fwd_i     (wb_res),
      .ex_req_o     (ex_req)
   );

   ex u_ex (
      .ex_req_i   (ex_req),
      .ex_res_o   (ex_res)
   );

   write_back u_write_back (
      .clk        (clk),
      .rst_i      (rst_i),
      .ex_res_i   (ex_res),
      .wb_o       (wb_res),
      .wb_we_o    (wb_we_o),
      .wb_addr_o  (wb_addr_o),
      .wb_data_o  (wb_data_o)
   );

endmodule

`default_nettype wire

/* verification/tb_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

   // ##############################
   // constants
   // ##############################
   localparam int CLK_HALF     = 4;                // 8 ns period
   localparam int RESET_CYCLES = 16;
   localparam int MAX_VECS     = 64;               // table capacity
   localparam int VEC_WORDS    = 6;                // words per table line
   localparam int F_GROUP      = 0;                // column offsets
   localparam int F_VALID      = 1;
   localparam int F_INST       = 2;
   localparam int F_WE         = 3;
   localparam int F_ADDR       = 4;
   localparam int F_DATA       = 5;
   localparam int END_GROUP    = 32'hf;            // last line of the table
   localparam int IDLE_SLOT    = -2;               // expect no write

   logic        clk = 1'b0;
   logic        rst;
   logic        inst_valid;
   logic [31:0] inst;
   logic        wb_we;
   logic [4:0]  wb_addr;
   logic [31:0] wb_data;

   logic [31:0] vec_mem [0:MAX_VECS*VEC_WORDS-1];  // flat vector table
   int          num_vecs;
   int          exp_q [$];                         // vector index per pipeline slot
   int          checks;
   int          errors;
   int          cycle_cnt;
   int          cycle_limit = 1000000;             // replaced once the table is loaded

   exec_core u_dut (
      .clk          (clk),
      .rst_i        (rst),
      .inst_valid_i (inst_valid),
      .inst_i       (inst),
      .wb_we_o      (wb_we),
      .wb_addr_o    (wb_addr),
      .wb_data_o    (wb_data)
   );

   always #CLK_HALF clk = ~clk;

   // ##############################
   // timeout
   // ##############################
   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // ##############################
   // helpers
   // ##############################
   function automatic string group_name(input logic [31:0] g);
      case (g)
         32'h1:   return "reset";
         32'h2:   return "logic";
         32'h3:   return "shift";
         32'h4:   return "arith";
         32'h5:   return "forward";
         32'h6:   return "bubble";
         default: return "unknown";
      endcase
   endfunction

   task automatic drive_vector(input int idx);
      inst_valid = vec_mem[idx*VEC_WORDS+F_VALID][0];
      inst       = vec_mem[idx*VEC_WORDS+F_INST];
   endtask

   // compares the write-back port against one queued slot
   task automatic check_slot(input int idx);
      logic        exp_we;
      logic [4:0]  exp_addr;
      logic [31:0] exp_data;
      string       name;
      if (idx == IDLE_SLOT)
      begin
         exp_we   = 1'b0;
         exp_addr = '0;
         exp_data = '0;
         name     = "reset idle";
      end
      else
      begin
         exp_we   = vec_mem[idx*VEC_WORDS+F_WE][0];
         exp_addr = vec_mem[idx*VEC_WORDS+F_ADDR][4:0];
         exp_data = vec_mem[idx*VEC_WORDS+F_DATA];
         name     = $sformatf("%s #%0d", group_name(vec_mem[idx*VEC_WORDS+F_GROUP]), idx);
      end
      checks = checks + 1;
      assert (wb_we === exp_we)
      else
      begin
         $display("** Error [%s] wb_we_o expected %0b actual %0b", name, exp_we, wb_we);
         errors = errors + 1;
      end
      if (exp_we)                                  // addr and data only matter on a write
      begin
         assert (wb_addr === exp_addr)
         else
         begin
            $display("** Error [%s] wb_addr_o expected %0d actual %0d",
                     name, exp_addr, wb_addr);
            errors = errors + 1;
         end
         assert (wb_data === exp_data)
         else
         begin
            $display("** Error [%s] wb_data_o expected 0x%08h actual 0x%08h",
                     name, exp_data, wb_data);
            errors = errors + 1;
         end
      end
   endtask

   // ##############################
   // main sequence
   // ##############################
   initial
   begin
      rst        = 1'b1;
      inst_valid = 1'b0;
      inst       = '0;
      checks     = 0;
      errors     = 0;
      cycle_cnt  = 0;
      num_vecs   = 0;

      $readmemh("verification/exec_vectors.txt", vec_mem);
      while ((num_vecs < MAX_VECS) && (vec_mem[num_vecs*VEC_WORDS+F_GROUP] !== END_GROUP))
         num_vecs = num_vecs + 1;
      if (num_vecs == MAX_VECS)
      begin
         $display("vector table has no end line, nothing was run");
         errors   = errors + 1;
         num_vecs = 0;
      end
      cycle_limit = num_vecs + RESET_CYCLES + 20;
      $display("loaded %0d vectors", num_vecs);

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;

      exp_q.push_back(IDLE_SLOT);                  // two edges before the first result
      exp_q.push_back(IDLE_SLOT);

      for (int k = 0; k < num_vecs; k++)
      begin
         @(posedge clk);
         #1;
         check_slot(exp_q.pop_front());
         drive_vector(k);
         exp_q.push_back(k);
      end

      // drain the two stages behind decode
      while (exp_q.size() > 0)
      begin
         @(posedge clk);
         #1;
         check_slot(exp_q.pop_front());
         inst_valid = 1'b0;
         inst       = '0;
      end

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
src/exec_pkg.sv
src/reg_file.sv
src/inst_decode.sv
src/ex.sv
src/write_back.sv
src/exec_core.sv
verification/tb_exec_core.sv

/* verification/exec_vectors.txt */
// group valid instruction exp_we exp_addr exp_data, all hex
// group 1 reset, 2 logic, 3 shift, 4 arith, 5 forward, 6 bubble, f ends the table
1 1 00E90825 1 01 00000000
1 1 27E20005 1 02 00000005
// logic
2 1 3C03F0F0 1 03 F0F00000
2 1 34631234 1 03 F0F01234
2 1 3404FF0F 1 04 0000FF0F
2 1 00642824 1 05 00001204
2 1 00643026 1 06 F0F0ED3B
2 1 00A63827 1 07 0F0F00C0
2 1 30E880F0 1 08 000000C0
2 1 3909FFFF 1 09 0000FF3F
// shift
3 1 3C0A8001 1 0a 80010000
3 1 000A5903 1 0b F8001000
3 1 000A6202 1 0c 00800100
3 1 000B6840 1 0d F0002000
3 1 240E0024 1 0e 00000024
3 1 01CD7807 1 0f FF000200
3 1 01CF8006 1 10 0FF00020
3 1 01D08804 1 11 FF000200
// arithmetic
4 1 26328000 1 12 FEFF8200
4 1 02329820 1 13 FDFF8400
4 1 0133A022 1 14 02017B3F
4 1 0274A82A 1 15 00000001
4 1 0274B02B 1 16 00000000
4 1 2A570010 1 17 00000001
4 1 2E580010 1 18 00000000
// forwarding chain
5 1 02B70821 1 01 00000002
5 1 00381023 1 02 00000002
5 1 00411821 1 03 00000004
5 1 00622021 1 04 00000006
5 1 00642804 1 05 00000060
5 1 00A43022 1 06 0000005A
5 1 00C53826 1 07 0000003A
5 1 24E70001 1 07 0000003B
5 1 00E04025 1 08 0000003B
// bubbles
6 0 24091111 0 00 00000000
6 1 8C0A0004 0 00 00000000
6 1 24005555 0 00 00000000
6 1 00095821 1 0b 0000FF3F
6 1 000A6025 1 0c 80010000
f 0 00000000 0 00 00000000
